//--- design/csr_addr_pkg.sv
package csr_addr_pkg;

    localparam int csr_addr_width = 12;

    ////////////////////
    // machine trap setup and handling
    localparam logic [csr_addr_width-1:0] csr_mstatus   = 12'h300;
    localparam logic [csr_addr_width-1:0] csr_misa      = 12'h301;
    localparam logic [csr_addr_width-1:0] csr_mie       = 12'h304;
    localparam logic [csr_addr_width-1:0] csr_mtvec     = 12'h305;
    localparam logic [csr_addr_width-1:0] csr_mscratch  = 12'h340;
    localparam logic [csr_addr_width-1:0] csr_mepc      = 12'h341;
    localparam logic [csr_addr_width-1:0] csr_mcause    = 12'h342;
    localparam logic [csr_addr_width-1:0] csr_mtval     = 12'h343;
    localparam logic [csr_addr_width-1:0] csr_mip       = 12'h344;

    ////////////////////
    // counters, machine and user views
    localparam logic [csr_addr_width-1:0] csr_mcycle    = 12'hB00;
    localparam logic [csr_addr_width-1:0] csr_minstret  = 12'hB02;
    localparam logic [csr_addr_width-1:0] csr_mcycleh   = 12'hB80;
    localparam logic [csr_addr_width-1:0] csr_minstreth = 12'hB82;
    localparam logic [csr_addr_width-1:0] csr_cycle     = 12'hC00;
    localparam logic [csr_addr_width-1:0] csr_time      = 12'hC01; // aliases cycle.
    localparam logic [csr_addr_width-1:0] csr_instret   = 12'hC02;
    localparam logic [csr_addr_width-1:0] csr_cycleh    = 12'hC80;
    localparam logic [csr_addr_width-1:0] csr_timeh     = 12'hC81;
    localparam logic [csr_addr_width-1:0] csr_instreth  = 12'hC82;

    // machine information, all read as zero.
    localparam logic [csr_addr_width-1:0] csr_mvendorid = 12'hF11;
    localparam logic [csr_addr_width-1:0] csr_marchid   = 12'hF12;
    localparam logic [csr_addr_width-1:0] csr_mimpid    = 12'hF13;
    localparam logic [csr_addr_width-1:0] csr_mhartid   = 12'hF14;

    ////////////////////
    // read-as-zero ranges
    localparam logic [csr_addr_width-1:0] csr_hpmevent_first     = 12'h323;
    localparam logic [csr_addr_width-1:0] csr_hpmevent_last      = 12'h33F;
    localparam logic [csr_addr_width-1:0] csr_pmpcfg_first       = 12'h3A0;
    localparam logic [csr_addr_width-1:0] csr_pmpaddr_last       = 12'h3BF;
    localparam logic [csr_addr_width-1:0] csr_hpmcounter_first   = 12'hB03;
    localparam logic [csr_addr_width-1:0] csr_hpmcounter_last    = 12'hB1F;
    localparam logic [csr_addr_width-1:0] csr_hpmcounterh_first  = 12'hB83;
    localparam logic [csr_addr_width-1:0] csr_hpmcounterh_last   = 12'hB9F;

    localparam logic [1:0] csr_op_write = 2'b00;
    localparam logic [1:0] csr_op_set   = 2'b01;
    localparam logic [1:0] csr_op_clear = 2'b10;

    localparam logic csr_src_imm = 1'b0;
    localparam logic csr_src_reg = 1'b1;

endpackage

//--- design/csr_field_pkg.sv
package csr_field_pkg;

    localparam int xlen          = 32;
    localparam int counter_width = 64;
    localparam int cause_width   = 4;

    ////////////////////
    // field positions
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mstatus_mpp_lo   = 11;
    localparam int mstatus_mpp_hi   = 12;

    // mip shares these positions.
    localparam int mie_msie_bit = 3;
    localparam int mie_mtie_bit = 7;
    localparam int mie_meie_bit = 11;

    localparam int mtvec_mode_bit       = 0;
    localparam int mcause_interrupt_bit = 31;

    // mxl = 1 for rv32, extension bit 8 for the base integer set.
    localparam logic [xlen-1:0] misa_value = 32'h4000_0100;

    ////////////////////
    // cause codes
    localparam logic [cause_width-1:0] cause_software_int     = 4'd3;
    localparam logic [cause_width-1:0] cause_timer_int        = 4'd7;
    localparam logic [cause_width-1:0] cause_external_int     = 4'd11;

    localparam logic [cause_width-1:0] cause_instr_misaligned = 4'd0;
    localparam logic [cause_width-1:0] cause_instr_fault      = 4'd1;
    localparam logic [cause_width-1:0] cause_illegal_instr    = 4'd2;
    localparam logic [cause_width-1:0] cause_breakpoint       = 4'd3;
    localparam logic [cause_width-1:0] cause_load_misaligned  = 4'd4;
    localparam logic [cause_width-1:0] cause_load_fault       = 4'd5;
    localparam logic [cause_width-1:0] cause_store_misaligned = 4'd6;
    localparam logic [cause_width-1:0] cause_store_fault      = 4'd7;
    localparam logic [cause_width-1:0] cause_ecall            = 4'd11;

endpackage

//--- design/csr_machine_regs.sv
`timescale 1ns/1ps

module csr_machine_regs
    import csr_addr_pkg::*;
    import csr_field_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  logic                      flush,
    input  logic                      exception,
    input  logic                      write,
    input  logic                      src,
    input  logic                      mret,
    input  logic [cause_width-1:0]    exception_cause,
    input  logic [1:0]                write_op,
    input  logic [xlen-1:0]           pc,
    input  logic [csr_addr_width-1:0] csr_addr,
    input  logic [xlen-1:0]           rs1_value,
    input  logic [xlen-1:0]           imm_value,
    output logic                      trap,
    output logic [xlen-1:0]           trap_pc,
    output logic [xlen-1:0]           machine_read_value,
    output logic                      machine_hit
);

    logic                   accepted;
    logic [xlen-1:0]        operand;
    logic [xlen-1:0]        new_value;

    logic                   mstatus_mie;
    logic                   mstatus_mpie;
    logic                   mie_meie;
    logic                   mie_mtie;
    logic                   mie_msie;
    logic [xlen-1:2]        mtvec_base;
    logic                   mtvec_mode;
    logic [xlen-1:0]        mscratch;
    logic [xlen-1:2]        mepc;
    logic                   mcause_interrupt;
    logic [cause_width-1:0] mcause_code;
    logic [xlen-1:0]        mtval;

    logic [xlen-1:0]        mstatus_value;
    logic [xlen-1:0]        mtvec_value;
    logic [xlen-1:0]        mcause_value;

    function automatic logic [xlen-1:0] pack_int_bits(
        input logic meie,
        input logic mtie,
        input logic msie
    );
        logic [xlen-1:0] value;
        value = '0;
        value[mie_meie_bit] = meie;
        value[mie_mtie_bit] = mtie;
        value[mie_msie_bit] = msie;
        return value;
    endfunction

    ////////////////////
    // read side

    always_comb begin
        mstatus_value = '0;
        mstatus_value[mstatus_mie_bit] = mstatus_mie;
        mstatus_value[mstatus_mpie_bit] = mstatus_mpie;
        mstatus_value[mstatus_mpp_hi:mstatus_mpp_lo] = '1; // always machine mode.

        mtvec_value = {mtvec_base, 2'b00};
        mtvec_value[mtvec_mode_bit] = mtvec_mode;

        mcause_value = '0;
        mcause_value[mcause_interrupt_bit] = mcause_interrupt;
        mcause_value[cause_width-1:0] = mcause_code;
    end

    always_comb begin
        machine_hit = 1'b1;
        machine_read_value = '0;
        case (csr_addr)
            csr_mstatus:  machine_read_value = mstatus_value;
            csr_mie:      machine_read_value = pack_int_bits(mie_meie, mie_mtie, mie_msie);
            csr_mtvec:    machine_read_value = mtvec_value;
            csr_mscratch: machine_read_value = mscratch;
            csr_mepc:     machine_read_value = {mepc, 2'b00};
            csr_mcause:   machine_read_value = mcause_value;
            csr_mtval:    machine_read_value = mtval;
            csr_mip:      machine_read_value = '0; // no interrupt sources reach this unit.
            default:      machine_hit = 1'b0;
        endcase
    end

    ////////////////////
    // write arithmetic

    always_comb begin
        case (src)
            csr_src_imm: operand = imm_value;
            csr_src_reg: operand = rs1_value;
            default:     operand = 'x;
        endcase

        case (write_op)
            csr_op_write: new_value = operand;
            csr_op_set:   new_value = machine_read_value | operand;
            csr_op_clear: new_value = machine_read_value & ~operand;
            default:      new_value = machine_read_value; // reserved op keeps the old value.
        endcase
    end

    ////////////////////
    // trap redirect

    assign accepted = !stall && !flush;
    assign trap     = accepted && (exception || mret);
    assign trap_pc  = exception ? {mtvec_base, 2'b00} : {mepc, 2'b00}; // exception beats mret.

    always_ff @(posedge clk) begin
        if (accepted) begin
            if (write) begin
                case (csr_addr)
                    csr_mstatus: begin
                        mstatus_mie  <= new_value[mstatus_mie_bit];
                        mstatus_mpie <= new_value[mstatus_mpie_bit];
                    end
                    csr_mie: begin
                        mie_meie <= new_value[mie_meie_bit];
                        mie_mtie <= new_value[mie_mtie_bit];
                        mie_msie <= new_value[mie_msie_bit];
                    end
                    csr_mtvec: begin
                        mtvec_base <= new_value[xlen-1:2];
                        mtvec_mode <= new_value[mtvec_mode_bit];
                    end
                    csr_mscratch: mscratch <= new_value;
                    csr_mepc:     mepc <= new_value[xlen-1:2];
                    csr_mcause: begin
                        mcause_interrupt <= new_value[mcause_interrupt_bit];
                        mcause_code      <= new_value[cause_width-1:0];
                    end
                    csr_mtval:    mtval <= new_value;
                    default: ;
                endcase
            end

            // placed after the write so the trap values win.
            if (exception) begin
                mepc             <= pc[xlen-1:2];
                mcause_interrupt <= 1'b0;
                mcause_code      <= exception_cause;
            end else if (mret) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
            end
        end

        if (reset) begin
            mstatus_mie      <= 1'b0;
            mcause_interrupt <= 1'b0;
            mcause_code      <= '0;
        end
    end

endmodule

//--- design/csr_counters.sv
`timescale 1ns/1ps

module csr_counters
    import csr_field_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     instr_retired,
    input  logic                     writeback_flush,
    output logic [counter_width-1:0] cycle_count,
    output logic [counter_width-1:0] instret_count
);

    logic retire;

    // a retirement squashed at writeback does not count.
    assign retire = instr_retired && !writeback_flush;

    ////////////////////
    // cycle counts every edge, stall or not

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instret_count <= '0;
        end else if (retire) begin
            instret_count <= instret_count + 1'b1;
        end
    end

endmodule

//--- design/csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux
    import csr_addr_pkg::*;
    import csr_field_pkg::*;
(
    input  logic [csr_addr_width-1:0] csr_addr,
    input  logic [xlen-1:0]           machine_read_value,
    input  logic                      machine_hit,
    input  logic [counter_width-1:0]  cycle_count,
    input  logic [counter_width-1:0]  instret_count,
    output logic [xlen-1:0]           read_value
);

    logic [xlen-1:0] cycle_lo;
    logic [xlen-1:0] cycle_hi;
    logic [xlen-1:0] instret_lo;
    logic [xlen-1:0] instret_hi;

    assign cycle_lo   = cycle_count[xlen-1:0];
    assign cycle_hi   = cycle_count[counter_width-1:xlen];
    assign instret_lo = instret_count[xlen-1:0];
    assign instret_hi = instret_count[counter_width-1:xlen];

    ////////////////////
    // read select

    always_comb begin
        if (machine_hit) begin
            read_value = machine_read_value;
        end else begin
            case (csr_addr) inside
                csr_misa: read_value = misa_value;

                // time has no timer of its own.
                csr_mcycle, csr_cycle, csr_time:    read_value = cycle_lo;
                csr_mcycleh, csr_cycleh, csr_timeh: read_value = cycle_hi;
                csr_minstret, csr_instret:          read_value = instret_lo;
                csr_minstreth, csr_instreth:        read_value = instret_hi;

                csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid: begin
                    read_value = '0;
                end

                [csr_hpmevent_first:csr_hpmevent_last],
                [csr_pmpcfg_first:csr_pmpaddr_last],
                [csr_hpmcounter_first:csr_hpmcounter_last],
                [csr_hpmcounterh_first:csr_hpmcounterh_last]: begin
                    read_value = '0; // unimplemented, hardwired zero.
                end

                default: read_value = 'x;
            endcase
        end
    end

endmodule

//--- design/csr_unit.sv
`timescale 1ns/1ps

module csr_unit
    import csr_addr_pkg::*;
    import csr_field_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  logic                      flush,
    input  logic                      writeback_flush,
    input  logic                      exception,
    input  logic [cause_width-1:0]    exception_cause,
    input  logic                      write,
    input  logic [1:0]                write_op,
    input  logic                      src,
    input  logic                      mret,
    input  logic                      instr_retired,
    input  logic [xlen-1:0]           pc,
    input  logic [csr_addr_width-1:0] csr_addr,
    input  logic [xlen-1:0]           rs1_value,
    input  logic [xlen-1:0]           imm_value,
    output logic                      trap,
    output logic [xlen-1:0]           read_value,
    output logic [xlen-1:0]           trap_pc,
    output logic [counter_width-1:0]  cycle
);

    logic [xlen-1:0]          machine_read_value;
    logic                     machine_hit;
    logic [counter_width-1:0] cycle_count;
    logic [counter_width-1:0] instret_count;

    assign cycle = cycle_count;

    ////////////////////
    // instances

    csr_machine_regs i_csr_machine_regs (
        .clk                (clk),
        .reset              (reset),
        .stall              (stall),
        .flush              (flush),
        .exception          (exception),
        .write              (write),
        .src                (src),
        .mret               (mret),
        .exception_cause    (exception_cause),
        .write_op           (write_op),
        .pc                 (pc),
        .csr_addr           (csr_addr),
        .rs1_value          (rs1_value),
        .imm_value          (imm_value),
        .trap               (trap),
        .trap_pc            (trap_pc),
        .machine_read_value (machine_read_value),
        .machine_hit        (machine_hit)
    );

    csr_counters i_csr_counters (
        .clk             (clk),
        .reset           (reset),
        .instr_retired   (instr_retired),
        .writeback_flush (writeback_flush),
        .cycle_count     (cycle_count),
        .instret_count   (instret_count)
    );

    csr_read_mux i_csr_read_mux (
        .csr_addr           (csr_addr),
        .machine_read_value (machine_read_value),
        .machine_hit        (machine_hit),
        .cycle_count        (cycle_count),
        .instret_count      (instret_count),
        .read_value         (read_value)
    );

endmodule

//--- sim/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb
    import csr_addr_pkg::*;
    import csr_field_pkg::*;
();

    localparam int          clk_period     = 20;
    localparam int unsigned rand_seed      = 32'hab9e0b1f;
    localparam int          test_count     = 40;
    localparam int          planned_cycles = 8 + 3 * test_count + 160;

    // mxl 1 for rv32, plus the i extension at bit 8.
    localparam logic [31:0] misa_expected  = 32'h4000_0100;

    logic                      clk, reset, stall, flush, writeback_flush;
    logic                      exception, write, src, mret, instr_retired, trap;
    logic [cause_width-1:0]    exception_cause;
    logic [1:0]                write_op;
    logic [xlen-1:0]           pc, rs1_value, imm_value, read_value, trap_pc;
    logic [csr_addr_width-1:0] csr_addr;
    logic [counter_width-1:0]  cycle;

    logic [xlen-1:0]           exp_csr [0:4095]; // expected read value per address.
    logic [counter_width-1:0]  exp_instret;
    logic [counter_width-1:0]  expected_cycle;
    longint unsigned           edge_count;
    longint unsigned           release_edge;
    logic                      released;
    int                        error_count;
    int                        check_count;
    logic [xlen-1:0]           value;
    logic [1:0]                rand_op;
    logic                      rand_src;
    logic [csr_addr_width-1:0] target_addr;
    logic [csr_addr_width-1:0] cycle_views [0:5];
    logic [csr_addr_width-1:0] instret_views [0:3];
    logic [csr_addr_width-1:0] zero_views [0:5];

    csr_unit i_csr_unit (
        .clk             (clk),
        .reset           (reset),
        .stall           (stall),
        .flush           (flush),
        .writeback_flush (writeback_flush),
        .exception       (exception),
        .exception_cause (exception_cause),
        .write           (write),
        .write_op        (write_op),
        .src             (src),
        .mret            (mret),
        .instr_retired   (instr_retired),
        .pc              (pc),
        .csr_addr        (csr_addr),
        .rs1_value       (rs1_value),
        .imm_value       (imm_value),
        .trap            (trap),
        .read_value      (read_value),
        .trap_pc         (trap_pc),
        .cycle           (cycle)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(planned_cycles * clk_period * 2);
        $display("timeout: the tests did not finish within %0d cycles", planned_cycles * 2);
        $display("Simulation failed");
        $finish;
    end

    always @(posedge clk) edge_count <= edge_count + 1;

    // cycle equals the edges seen since reset release.
    always @(negedge clk) begin
        if (released) begin
            check_value("cycle output", edge_count - release_edge, cycle);
        end
    end

    ////////////////////
    // tasks

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    function automatic logic [xlen-1:0] stored_value(input logic [csr_addr_width-1:0] addr,
                                                     input logic [xlen-1:0] v);
        case (addr)
            csr_mstatus: return (v & 32'h0000_0088) | 32'h0000_1800; // mpp reads as 11.
            csr_mie:     return v & 32'h0000_0888;
            csr_mtvec:   return v & 32'hFFFF_FFFD;
            csr_mepc:    return v & 32'hFFFF_FFFC;
            csr_mcause:  return v & 32'h8000_000F;
            default:     return v;
        endcase
    endfunction

    task automatic read_csr(input logic [csr_addr_width-1:0] addr, output logic [xlen-1:0] v);
        @(posedge clk);
        #2;
        csr_addr = addr;
        @(negedge clk);
        v = read_value;
    endtask

    task automatic expect_csr(input string name, input logic [csr_addr_width-1:0] addr);
        logic [xlen-1:0] v;
        read_csr(addr, v);
        check_value(name, exp_csr[addr], v);
    endtask

    task automatic set_pipeline(input logic hold, input logic kill);
        @(posedge clk);
        #2;
        stall = hold;
        flush = kill;
    endtask

    task automatic csr_write(input logic [csr_addr_width-1:0] addr, input logic [1:0] op,
                             input logic use_reg, input logic [xlen-1:0] operand);
        logic            accepted;
        logic [xlen-1:0] result;
        @(posedge clk);
        #2;
        write     = 1'b1;
        csr_addr  = addr;
        write_op  = op;
        src       = use_reg ? csr_src_reg : csr_src_imm;
        rs1_value = use_reg ? operand : $urandom; // the unused source carries noise.
        imm_value = use_reg ? $urandom : operand;
        accepted  = !stall && !flush;
        @(posedge clk);
        #2;
        write = 1'b0;
        if (accepted) begin
            case (op)
                csr_op_set:   result = exp_csr[addr] | operand;
                csr_op_clear: result = exp_csr[addr] & ~operand;
                default:      result = operand;
            endcase
            exp_csr[addr] = stored_value(addr, result);
        end
    endtask

    task automatic trap_event(input logic exc, input logic ret,
                              input logic [cause_width-1:0] cause, input logic [xlen-1:0] pc_value);
        logic            taken;
        logic [xlen-1:0] target;
        @(posedge clk);
        #2;
        exception       = exc;
        mret            = ret;
        exception_cause = cause;
        pc              = pc_value;
        taken           = !stall && !flush;
        target          = exc ? exp_csr[csr_mtvec] & 32'hFFFF_FFFC : exp_csr[csr_mepc];
        @(negedge clk);
        check_value("trap", taken, trap);
        if (taken) begin
            check_value("trap_pc", target, trap_pc);
        end
        @(posedge clk);
        #2;
        exception = 1'b0;
        mret      = 1'b0;
        if (taken && exc) begin
            exp_csr[csr_mepc]   = pc_value & 32'hFFFF_FFFC;
            exp_csr[csr_mcause] = cause; // interrupt bit clear.
        end else if (taken && ret) begin
            exp_csr[csr_mstatus][mstatus_mie_bit]  = exp_csr[csr_mstatus][mstatus_mpie_bit];
            exp_csr[csr_mstatus][mstatus_mpie_bit] = 1'b1;
        end
    endtask

    task automatic retire(input logic cancelled);
        @(posedge clk);
        #2;
        instr_retired   = 1'b1;
        writeback_flush = cancelled;
        @(posedge clk);
        #2;
        instr_retired   = 1'b0;
        writeback_flush = 1'b0;
        if (!cancelled) begin
            exp_instret++;
        end
    endtask

    ////////////////////
    // test sequence

    initial begin
        void'($urandom(rand_seed));
        reset           = 1'b1;
        stall           = 1'b0;
        flush           = 1'b0;
        writeback_flush = 1'b0;
        exception       = 1'b0;
        exception_cause = '0;
        write           = 1'b0;
        write_op        = csr_op_write;
        src             = csr_src_imm;
        mret            = 1'b0;
        instr_retired   = 1'b0;
        pc              = '0;
        csr_addr        = csr_mscratch;
        rs1_value       = '0;
        imm_value       = '0;
        edge_count      = 0;
        released        = 1'b0;
        error_count     = 0;
        check_count     = 0;
        exp_instret     = '0;
        cycle_views     = '{csr_mcycle, csr_mcycleh, csr_cycle, csr_cycleh, csr_time, csr_timeh};
        instret_views   = '{csr_minstret, csr_minstreth, csr_instret, csr_instreth};
        zero_views      = '{csr_hpmevent_first, csr_pmpcfg_first, csr_pmpaddr_last,
                            csr_hpmcounter_last, csr_hpmcounterh_first, csr_mhartid};

        repeat (8) @(posedge clk);
        #2;
        reset        = 1'b0;
        release_edge = edge_count;
        released     = 1'b1;

        @(negedge clk);
        check_value("trap after reset", 1'b0, trap);
        read_csr(csr_mstatus, value);
        check_value("mstatus mie after reset", 1'b0, value[mstatus_mie_bit]);
        exp_csr[csr_mcause] = '0;
        expect_csr("mcause after reset", csr_mcause);

        // counters, every view of both halves.
        for (int i = 0; i < 6; i++) begin
            read_csr(cycle_views[i], value);
            expected_cycle = edge_count - release_edge;
            check_value("cycle view", i % 2 ? expected_cycle[63:32] : expected_cycle[31:0], value);
        end
        for (int i = 0; i < 20; i++) begin
            retire(($urandom & 1) != 0);
        end
        for (int i = 0; i < 4; i++) begin
            read_csr(instret_views[i], value);
            check_value("instret view", i % 2 ? exp_instret[63:32] : exp_instret[31:0], value);
        end

        // write, set and clear on the plain registers.
        csr_write(csr_mscratch, csr_op_write, 1'b1, $urandom);
        csr_write(csr_mtval, csr_op_write, 1'b0, $urandom);
        for (int i = 0; i < test_count; i++) begin
            target_addr = (i % 2) ? csr_mscratch : csr_mtval;
            rand_op     = $urandom % 3;
            rand_src    = $urandom % 2;
            csr_write(target_addr, rand_op, rand_src, $urandom);
            expect_csr((i % 2) ? "mscratch write op" : "mtval write op", target_addr);
        end

        csr_write(csr_mstatus, csr_op_write, 1'b1, $urandom);
        expect_csr("mstatus mask", csr_mstatus);
        csr_write(csr_mie, csr_op_write, 1'b0, $urandom);
        expect_csr("mie mask", csr_mie);
        csr_write(csr_mtvec, csr_op_write, 1'b1, $urandom);
        expect_csr("mtvec mask", csr_mtvec);
        csr_write(csr_mepc, csr_op_write, 1'b1, $urandom);
        expect_csr("mepc mask", csr_mepc);
        // interrupt bit set, so the next exception has to clear it.
        csr_write(csr_mcause, csr_op_write, 1'b0, $urandom | 32'h8000_0000);
        expect_csr("mcause mask", csr_mcause);
        read_csr(csr_misa, value);
        check_value("misa", misa_expected, value);
        for (int i = 0; i < 6; i++) begin
            read_csr(zero_views[i], value);
            check_value("read-as-zero range", '0, value);
        end

        ////////////////////
        // traps
        trap_event(1'b1, 1'b0, cause_illegal_instr, $urandom);
        expect_csr("mepc after exception", csr_mepc);
        expect_csr("mcause after exception", csr_mcause);
        trap_event(1'b1, 1'b1, cause_ecall, $urandom); // exception beats mret.
        expect_csr("mepc after exception with mret", csr_mepc);
        expect_csr("mcause after exception with mret", csr_mcause);
        expect_csr("mstatus after exception with mret", csr_mstatus);
        for (int i = 0; i < 4; i++) begin
            csr_write(csr_mstatus, csr_op_write, 1'b0, $urandom);
            trap_event(1'b0, 1'b1, '0, $urandom);
            expect_csr("mstatus after mret", csr_mstatus);
        end

        // stall first, then flush.
        for (int i = 0; i < 2; i++) begin
            set_pipeline(i == 0, i == 1);
            csr_write(csr_mscratch, csr_op_write, 1'b1, $urandom);
            trap_event(1'b1, 1'b0, cause_ecall, $urandom);
            trap_event(1'b0, 1'b1, '0, $urandom);
            set_pipeline(1'b0, 1'b0);
            expect_csr("mscratch while blocked", csr_mscratch);
            expect_csr("mepc while blocked", csr_mepc);
            expect_csr("mcause while blocked", csr_mcause);
            expect_csr("mstatus while blocked", csr_mstatus);
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sim.f
design/csr_addr_pkg.sv
design/csr_field_pkg.sv
design/csr_machine_regs.sv
design/csr_counters.sv
design/csr_read_mux.sv
design/csr_unit.sv
sim/csr_unit_tb.sv
